//--- design/ifu_pkg.sv
package ifu_pkg;

    // bus and datapath widths
    localparam int INST_ADDR_WIDTH = 32;
    localparam int INST_DATA_WIDTH = 32;

    typedef logic [INST_ADDR_WIDTH-1:0] inst_addr_t;   // byte address, word aligned
    typedef logic [INST_DATA_WIDTH-1:0] inst_data_t;   // one rv32 instruction word

    // first fetch after reset
    localparam inst_addr_t PC_RESET_ADDR = 32'h0000_0000;

    // major opcodes seen by the predictor
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;   // jal
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;   // beq/bne/blt/bge/bltu/bgeu

    // IF/ID stage register contents
    typedef struct packed {
        inst_data_t inst;        // fetched word
        inst_addr_t inst_addr;   // where it came from
        logic       valid;       // slot holds a real instruction
        logic       pred_taken;  // predictor redirected fetch on this one
    } if_id_t;

    // oldest filled entry of the fetch queue
    typedef struct packed {
        inst_data_t inst;
        inst_addr_t inst_addr;
        logic       valid;       // head is filled and may be popped
    } fetch_rsp_t;

endpackage

//--- design/ifu_fetch_queue.sv
`timescale 1ns/1ps

module ifu_fetch_queue import ifu_pkg::*; #(
    parameter int QUEUE_DEPTH = 4   // power of two, 2..8
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       issue_i,    // address accepted on the bus
    input  inst_addr_t addr_i,     // address of that request
    input  logic       rvalid_i,   // response strobe, in order
    input  inst_data_t rdata_i,
    input  logic       pop_i,      // head taken by the IF stage
    input  logic       flush_i,    // redirect, drop younger work
    output logic       credit_o,   // room for one more request
    output fetch_rsp_t head_o
);

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    typedef logic [IDX_W:0]   ptr_t;   // slot index plus wrap bit
    typedef logic [IDX_W-1:0] idx_t;   // plain slot index
    typedef logic [IDX_W+1:0] cnt_t;   // alloc + discard, one spare bit

    // slot storage, payload only
    inst_addr_t addr_mem [QUEUE_DEPTH];
    inst_data_t data_mem [QUEUE_DEPTH];

    logic [QUEUE_DEPTH-1:0] filled_q;   // response has landed in slot

    // three pointers walk the ring in order: rd <= fill <= wr
    ptr_t rd_ptr_q;     // oldest allocated slot (head)
    ptr_t fill_ptr_q;   // next slot a response goes into
    ptr_t wr_ptr_q;     // next slot to allocate on issue
    ptr_t discard_q;    // responses still owed to a flushed path

    ptr_t alloc_cnt;
    ptr_t unfilled_cnt;
    ptr_t pending;
    idx_t rd_idx;
    idx_t fill_idx;
    idx_t wr_idx;
    logic rsp_dropped;

    assign rd_idx   = rd_ptr_q[IDX_W-1:0];
    assign fill_idx = fill_ptr_q[IDX_W-1:0];
    assign wr_idx   = wr_ptr_q[IDX_W-1:0];

    assign alloc_cnt    = wr_ptr_q - rd_ptr_q;     // slots in use
    assign unfilled_cnt = wr_ptr_q - fill_ptr_q;   // issued, no data yet
    assign pending      = discard_q + unfilled_cnt; // all responses in flight

    // stale response, eaten by the discard count
    assign rsp_dropped = rvalid_i && (discard_q != '0);

    // every in-flight response needs a place, live slot or discard
    assign credit_o = (cnt_t'(alloc_cnt) + cnt_t'(discard_q)) < cnt_t'(QUEUE_DEPTH);

    // head is always the oldest slot, valid once it is filled
    assign head_o.inst      = data_mem[rd_idx];
    assign head_o.inst_addr = addr_mem[rd_idx];
    assign head_o.valid     = filled_q[rd_idx];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ptr_q   <= '0;
            fill_ptr_q <= '0;
            wr_ptr_q   <= '0;
            discard_q  <= '0;
            filled_q   <= '0;
        end else if (flush_i) begin
            // ring empties, popped head has already left
            rd_ptr_q   <= wr_ptr_q;
            fill_ptr_q <= wr_ptr_q;
            filled_q   <= '0;
            // outstanding requests turn into discards
            // a response in this very cycle is already accounted for
            discard_q  <= pending - ptr_t'(rvalid_i);
        end else begin
            if (issue_i) begin
                wr_ptr_q <= wr_ptr_q + ptr_t'(1);   // allocate
            end
            if (rvalid_i) begin
                if (rsp_dropped) begin
                    discard_q <= discard_q - ptr_t'(1);
                end else begin
                    filled_q[fill_idx] <= 1'b1;
                    fill_ptr_q         <= fill_ptr_q + ptr_t'(1);
                end
            end
            if (pop_i) begin
                filled_q[rd_idx] <= 1'b0;   // slot free again
                rd_ptr_q         <= rd_ptr_q + ptr_t'(1);
            end
        end
    end

    // payload writes, no reset needed
    always_ff @(posedge clk) begin
        if (issue_i) begin
            addr_mem[wr_idx] <= addr_i;   // remember what was asked for
        end
        if (rvalid_i && !rsp_dropped) begin
            data_mem[fill_idx] <= rdata_i;
        end
    end

endmodule

//--- design/sbpu.sv
`timescale 1ns/1ps

// static predictor, looks only at the word leaving the fetch queue
module sbpu import ifu_pkg::*; (
    input  inst_data_t inst_i,        // popped instruction word
    input  inst_addr_t inst_addr_i,   // its address
    input  logic       inst_valid_i,  // word is really being popped
    output logic       taken_o,       // redirect fetch
    output inst_addr_t target_o       // predicted next pc
);

    logic [6:0] opcode;
    logic       is_jal;
    logic       is_branch;
    logic       back_branch;
    inst_addr_t imm_j;
    inst_addr_t imm_b;
    inst_addr_t offset;

    assign opcode = inst_i[6:0];

    // predecode, gated by valid so idle head never redirects
    assign is_jal    = inst_valid_i && (opcode == OPC_JAL);
    assign is_branch = inst_valid_i && (opcode == OPC_BRANCH);

    // J-type immediate, bit 0 implied zero
    assign imm_j = {
        {(INST_ADDR_WIDTH-20){inst_i[31]}},   // sign
        inst_i[19:12],
        inst_i[20],
        inst_i[30:21],
        1'b0
    };

    // B-type immediate, bit 0 implied zero
    assign imm_b = {
        {(INST_ADDR_WIDTH-12){inst_i[31]}},   // sign
        inst_i[7],
        inst_i[30:25],
        inst_i[11:8],
        1'b0
    };

    // sign bit of B-imm set means a backward branch, likely a loop
    assign back_branch = is_branch && inst_i[31];

    // jal always goes, branches only backward
    assign taken_o = is_jal || back_branch;

    assign offset   = is_jal ? imm_j : imm_b;
    assign target_o = inst_addr_i + offset;   // pc relative

endmodule

//--- design/ifu_pipe.sv
`timescale 1ns/1ps

module ifu_pipe import ifu_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    input  logic   stall_i,   // hold IF/ID
    input  logic   flush_i,   // kill what is in IF/ID
    input  if_id_t d_i,
    output if_id_t q_o
);

    logic       valid_q;       // control bit, the only one reset
    logic       pred_taken_q;
    inst_data_t inst_q;
    inst_addr_t inst_addr_q;

    // valid: reset and flush win over stall
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= d_i.valid;
        end
    end

    // payload follows the stall only
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            inst_q       <= d_i.inst;
            inst_addr_q  <= d_i.inst_addr;
            pred_taken_q <= d_i.pred_taken;   // meaningful only with valid
        end
    end

    assign q_o.inst       = inst_q;
    assign q_o.inst_addr  = inst_addr_q;
    assign q_o.valid      = valid_q;
    assign q_o.pred_taken = pred_taken_q;

endmodule

//--- design/ifu_ifetch.sv
`timescale 1ns/1ps

module ifu_ifetch import ifu_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       stall_i,       // IF stage held by a later stage
    input  logic       jump_i,        // resolved redirect, one cycle
    input  inst_addr_t jump_addr_i,
    input  logic       arready_i,
    input  logic       credit_i,      // queue can take another request
    input  fetch_rsp_t head_i,        // oldest filled queue entry
    output logic       arvalid_o,
    output inst_addr_t araddr_o,
    output logic       issue_o,       // handshake done this cycle
    output logic       pop_o,         // head moves into IF/ID
    output logic       flush_o,       // drop younger queue entries
    output if_id_t     if_id_o
);

    inst_addr_t pc_q;
    logic       fetch_en_q;    // low in the first cycle out of reset
    logic       pred_taken;
    inst_addr_t pred_target;
    if_id_t     pipe_d;

    assign pop_o   = head_i.valid && !stall_i;
    assign flush_o = jump_i || pred_taken;   // either redirect

    // no new request while stalled or while the path is changing
    assign arvalid_o = fetch_en_q && credit_i && !stall_i && !flush_o;
    assign araddr_o  = pc_q;
    assign issue_o   = arvalid_o && arready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_en_q <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
        end
    end

    // pc: reset, jump, prediction, +4 on accept, else hold
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= PC_RESET_ADDR;
        end else if (jump_i) begin
            pc_q <= jump_addr_i;     // later stage wins
        end else if (pred_taken) begin
            pc_q <= pred_target;
        end else if (issue_o) begin
            pc_q <= pc_q + 32'd4;    // next word
        end
    end

    // predecode only the word actually leaving the queue
    sbpu u_sbpu (
        .inst_i      (head_i.inst),
        .inst_addr_i (head_i.inst_addr),
        .inst_valid_i(pop_o),
        .taken_o     (pred_taken),
        .target_o    (pred_target)
    );

    always_comb begin
        pipe_d.inst       = head_i.inst;
        pipe_d.inst_addr  = head_i.inst_addr;
        pipe_d.valid      = head_i.valid;   // stall holds the register anyway
        pipe_d.pred_taken = pred_taken;
    end

    // predicted branch itself still goes down, only a jump kills IF/ID
    ifu_pipe u_ifu_pipe (
        .clk    (clk),
        .reset_i(reset_i),
        .stall_i(stall_i),
        .flush_i(jump_i),
        .d_i    (pipe_d),
        .q_o    (if_id_o)
    );

endmodule

//--- design/ifu_top.sv
`timescale 1ns/1ps

module ifu_top import ifu_pkg::*; #(
    parameter int QUEUE_DEPTH = 4   // outstanding fetch slots
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       stall_i,       // hold IF
    input  logic       jump_i,        // redirect strobe
    input  inst_addr_t jump_addr_i,
    // read address channel
    input  logic       arready_i,
    output logic       arvalid_o,
    output inst_addr_t araddr_o,
    // read data channel, always accepted
    input  logic       rvalid_i,
    input  inst_data_t rdata_i,
    // to decode
    output if_id_t     if_id_o
);

    logic       credit;
    logic       issue;
    logic       pop;
    logic       flush;
    fetch_rsp_t head;

    // pc, handshake, predictor, IF/ID
    ifu_ifetch u_ifu_ifetch (
        .clk        (clk),
        .reset_i    (reset_i),
        .stall_i    (stall_i),
        .jump_i     (jump_i),
        .jump_addr_i(jump_addr_i),
        .arready_i  (arready_i),
        .credit_i   (credit),
        .head_i     (head),
        .arvalid_o  (arvalid_o),
        .araddr_o   (araddr_o),
        .issue_o    (issue),
        .pop_o      (pop),
        .flush_o    (flush),
        .if_id_o    (if_id_o)
    );

    // keeps responses in request order
    ifu_fetch_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_ifu_fetch_queue (
        .clk     (clk),
        .reset_i (reset_i),
        .issue_i (issue),
        .addr_i  (araddr_o),   // address accepted this cycle
        .rvalid_i(rvalid_i),
        .rdata_i (rdata_i),
        .pop_i   (pop),
        .flush_i (flush),
        .credit_o(credit),
        .head_o  (head)
    );

endmodule

//--- tb/ifu_assert.sv
`timescale 1ns/1ps

module ifu_assert import ifu_pkg::*; (
    input logic       clk,
    input logic       reset_i,
    input logic       stall_i,
    input logic       jump_i,
    input logic       arready_i,
    input logic       arvalid_i,   // observed arvalid_o
    input inst_addr_t araddr_i,    // observed araddr_o
    input if_id_t     if_id_i      // observed if_id_o
);

    // no request in reset, the cycle after it, or under stall
    property no_req_when_held;
        @(posedge clk) (stall_i || $past(reset_i)) |-> !arvalid_i;
    endproperty

    property addr_aligned;
        @(posedge clk) disable iff (reset_i)
            arvalid_i |-> (araddr_i[1:0] == 2'b00);
    endproperty

    // jump kills IF/ID one cycle later
    property jump_clears_if_id;
        @(posedge clk) disable iff (reset_i)
            jump_i |=> !if_id_i.valid;
    endproperty

    // waiting request keeps its address, a redirect drops arvalid instead
    property addr_held_under_backpressure;
        @(posedge clk) disable iff (reset_i)
            (arvalid_i && !arready_i) |=> ($stable(araddr_i) || !arvalid_i);
    endproperty

    a_no_req: assert property (no_req_when_held)
        else $error("arvalid_o high during reset or stall");
    a_aligned: assert property (addr_aligned)
        else $error("araddr_o not word aligned");
    a_jump_flush: assert property (jump_clears_if_id)
        else $error("if_id_o.valid high in the cycle after jump_i");
    a_addr_stable: assert property (addr_held_under_backpressure)
        else $error("araddr_o changed while waiting for arready_i");

endmodule

bind ifu_top ifu_assert u_ifu_assert (
    .clk      (clk),
    .reset_i  (reset_i),
    .stall_i  (stall_i),
    .jump_i   (jump_i),
    .arready_i(arready_i),
    .arvalid_i(arvalid_o),
    .araddr_i (araddr_o),
    .if_id_i  (if_id_o)
);

//--- tb/ifu_tb.sv
`timescale 1ns/1ps

module ifu_tb import ifu_pkg::*;;

    // one stimulus row: where to start, how many to collect, which noise
    typedef struct packed {
        inst_addr_t start;      // jump target, row 0 starts from reset
        int         count;      // instructions to collect
        logic       stall_en;   // random stall_i
        logic       rand_en;    // random arready_i gaps
    } row_t;

    // control transfer patched into the image
    typedef struct packed {
        inst_addr_t addr;
        logic       is_jal;     // else conditional branch
        inst_addr_t offset;     // signed, pc relative
    } patch_t;

    localparam int NUM_ROWS    = 6;
    localparam int NUM_PATCHES = 5;
    localparam int MEM_WORDS   = 256;   // 1 KB image, fill pattern above it

    localparam row_t ROWS [NUM_ROWS] = '{
        '{32'h0000_0000, 40, 1'b0, 1'b0},   // reset start, through jal and loop
        '{32'h0000_0200, 30, 1'b1, 1'b1},   // backward jal into a chained jal
        '{32'h0000_00f0, 30, 1'b1, 1'b1},   // forward and backward branch
        '{32'h0000_0030, 20, 1'b0, 1'b1},
        '{32'h0000_0300, 24, 1'b1, 1'b0},   // tight loop under stalls
        '{32'h0000_0010, 12, 1'b0, 1'b0}
    };

    localparam patch_t PATCHES [NUM_PATCHES] = '{
        '{32'h0000_0040, 1'b1, 32'h0000_00c0},   // jal to 0x100
        '{32'h0000_0110, 1'b0, 32'h0000_0020},   // forward branch, not taken
        '{32'h0000_0120, 1'b0, 32'hffff_ffe8},   // back to 0x108
        '{32'h0000_0240, 1'b1, 32'hffff_fdf0},   // back to 0x030
        '{32'h0000_031c, 1'b0, 32'hffff_ffe4}    // back to 0x300
    };

    logic       clk = 1'b0;
    logic       reset_i;
    logic       stall_i;
    logic       jump_i;
    inst_addr_t jump_addr_i;
    logic       arready_i;
    logic       rvalid_i;
    inst_data_t rdata_i;
    logic       arvalid_o;
    inst_addr_t araddr_o;
    if_id_t     if_id_o;

    integer     seed = 32'h09e5ce08;
    inst_data_t mem [MEM_WORDS];
    inst_addr_t addr_fifo [$];   // accepted requests, oldest first
    int         due_fifo [$];    // cycle each one is answered
    int         cyc = 0;
    int         last_due = 0;
    logic       stall_en = 1'b0;
    logic       rand_en = 1'b0;

    // checker state, written with nonblocking only
    inst_addr_t exp_pc = PC_RESET_ADDR;
    int         row_seen = 0;
    int         checks = 0;
    int         errors = 0;
    logic       in_reset = 1'b0;
    logic       hold_pending = 1'b0;
    if_id_t     held_if_id;

    always #4 clk = ~clk;   // 8 ns

    ifu_top #(
        .QUEUE_DEPTH(4)
    ) DUT (
        .clk        (clk),
        .reset_i    (reset_i),
        .stall_i    (stall_i),
        .jump_i     (jump_i),
        .jump_addr_i(jump_addr_i),
        .arready_i  (arready_i),
        .arvalid_o  (arvalid_o),
        .araddr_o   (araddr_o),
        .rvalid_i   (rvalid_i),
        .rdata_i    (rdata_i),
        .if_id_o    (if_id_o)
    );

    // op-imm word, every address bit folded in
    function automatic inst_data_t fill_word(inst_addr_t a);
        return {a[31:7] ^ a[24:0], 7'b0010011};
    endfunction

    function automatic inst_data_t jal_word(inst_addr_t off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};   // rd = ra
    endfunction

    function automatic inst_data_t branch_word(inst_addr_t off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b001, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic int find_patch(inst_addr_t pc);
        for (int k = 0; k < NUM_PATCHES; k++) begin
            if (PATCHES[k].addr == pc) return k;
        end
        return -1;
    endfunction

    function automatic inst_data_t image_word(inst_addr_t a);
        if (a[31:10] == '0) return mem[a[9:2]];
        return fill_word(a);   // beyond the array
    endfunction

    // static rule: jal always, branch only with negative offset
    function automatic logic predicts_taken(inst_addr_t pc);
        int k;
        k = find_patch(pc);
        if (k < 0) return 1'b0;
        return PATCHES[k].is_jal || PATCHES[k].offset[INST_ADDR_WIDTH-1];
    endfunction

    function automatic inst_addr_t next_pc(inst_addr_t pc);
        int k;
        k = find_patch(pc);
        if (predicts_taken(pc)) return pc + PATCHES[k].offset;
        return pc + 32'd4;
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(inst_addr_t'(i * 4));
        end
        for (int k = 0; k < NUM_PATCHES; k++) begin
            mem[PATCHES[k].addr[9:2]] = PATCHES[k].is_jal ? jal_word(PATCHES[k].offset)
                                                          : branch_word(PATCHES[k].offset);
        end
    end

    // bus slave and stall source, all random draws live here
    always @(posedge clk) begin
        int         lat;
        int         due;
        inst_addr_t a;
        cyc = cyc + 1;
        if (reset_i) begin
            addr_fifo.delete();
            due_fifo.delete();
            last_due = 0;
            rvalid_i  <= 1'b0;
            arready_i <= 1'b1;
            stall_i   <= 1'b0;
        end else begin
            if (arvalid_o && arready_i) begin   // handshake in the cycle just ended
                lat = int'($unsigned($random(seed)) % 4) + 1;
                due = cyc + lat - 1;
                if (due <= last_due) due = last_due + 1;   // stay in order
                last_due = due;
                addr_fifo.push_back(araddr_o);
                due_fifo.push_back(due);
            end
            if (due_fifo.size() > 0 && due_fifo[0] <= cyc) begin
                a = addr_fifo.pop_front();
                void'(due_fifo.pop_front());
                rvalid_i <= 1'b1;
                rdata_i  <= image_word(a);
            end else begin
                rvalid_i <= 1'b0;
            end
            arready_i <= rand_en ? (($random(seed) % 4) != 0) : 1'b1;
            stall_i   <= stall_en && (($random(seed) % 4) == 0);
        end
    end

    // compares every instruction that decode takes
    always @(posedge clk) begin
        int bad;
        bad = 0;
        if (reset_i) begin
            if (in_reset && if_id_o.valid !== 1'b0) begin
                $display("ERROR at %0t: IF/ID valid during reset", $time);
                bad++;
            end
            exp_pc   <= PC_RESET_ADDR;
            row_seen <= 0;
        end else begin
            if (jump_i) begin
                exp_pc   <= jump_addr_i;   // old path dies here
                row_seen <= 0;
            end else if (if_id_o.valid && !stall_i) begin
                if (if_id_o.inst_addr !== exp_pc || if_id_o.inst !== image_word(exp_pc)
                        || if_id_o.pred_taken !== predicts_taken(exp_pc)) begin
                    $display("ERROR at %0t: got addr %h inst %h pred %b, expected %h %h %b",
                             $time, if_id_o.inst_addr, if_id_o.inst, if_id_o.pred_taken,
                             exp_pc, image_word(exp_pc), predicts_taken(exp_pc));
                    bad++;
                end
                exp_pc   <= next_pc(exp_pc);
                row_seen <= row_seen + 1;
                checks   <= checks + 1;
            end
            if (hold_pending && if_id_o !== held_if_id) begin
                $display("ERROR at %0t: IF/ID changed while stalled", $time);
                bad++;
            end
        end
        in_reset     <= reset_i;
        hold_pending <= !reset_i && stall_i && !jump_i;   // flush may clear it
        held_if_id   <= if_id_o;
        errors       <= errors + bad;
    end

    // row loop
    initial begin
        int base_err;
        base_err    = 0;
        reset_i     = 1'b1;
        stall_i     = 1'b0;
        jump_i      = 1'b0;
        jump_addr_i = '0;
        arready_i   = 1'b0;
        rvalid_i    = 1'b0;
        rdata_i     = '0;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (r > 0) begin
                @(posedge clk);
                jump_i      <= 1'b1;
                jump_addr_i <= ROWS[r].start;
            end
            stall_en <= ROWS[r].stall_en;
            rand_en  <= ROWS[r].rand_en;
            if (r > 0) begin
                @(posedge clk);
                jump_i <= 1'b0;
                @(posedge clk);   // checker has restarted the row count
            end
            while (row_seen < ROWS[r].count) @(posedge clk);
            @(negedge clk);
            $display("row %0d: start %h, %0d instructions, %0d errors",
                     r, ROWS[r].start, ROWS[r].count, errors - base_err);
            base_err = errors;
        end
        $display("rows %0d, instructions checked %0d, errors %0d", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog, 40 cycles per requested instruction
    initial begin
        int total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += ROWS[i].count;
        end
        @(negedge reset_i);
        repeat (total * 40) @(posedge clk);
        $display("TIMEOUT: fetch stream did not finish within %0d cycles", total * 40);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- all.f
design/ifu_pkg.sv
design/ifu_fetch_queue.sv
design/sbpu.sv
design/ifu_pipe.sv
design/ifu_ifetch.sv
design/ifu_top.sv
tb/ifu_assert.sv
tb/ifu_tb.sv

//--- Makefile
SIM = obj_dir/ifu_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module ifu_tb -f all.f -o ifu_sim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
